//--- files.f
+incdir+sim
design/reg_pkg.sv
design/reg_wr_if.sv
design/reg_file.sv
design/ptr_step.sv
design/ea_combine.sv
design/regs_ea_top.sv
sim/regs_ea_tb.sv

//--- sim/regs_ea_tb_checks.svh
// compare tasks for the register file testbench, one per result kind
// plus the bounded wait for the address strobe

`ifndef REGS_EA_TB_CHECKS_SVH
`define REGS_EA_TB_CHECKS_SVH

// register long, read port data
task automatic check_long(input string name, input reg_pkg::reg_long_t got,
                          input reg_pkg::reg_long_t exp);
    if (got !== exp)
        abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
endtask

// 24-bit effective address
task automatic check_ea(input string name, input reg_pkg::ea_addr_t got,
                        input reg_pkg::ea_addr_t exp);
    if (got !== exp)
        abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
endtask

// single-bit strobe, X counts as wrong
task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp)
        abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
endtask

// returns at the first falling edge with ea_valid high
task automatic wait_ea_valid();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while ((ea_valid !== 1'b1) && (cycles < VALID_TIMEOUT)) begin
        @(negedge clk);
        cycles++;
    end
    if (ea_valid !== 1'b1)
        abort_run($sformatf("ea_valid never arrived within %0d cycles of the request",
                            VALID_TIMEOUT));
endtask

`endif

//--- sim/regs_ea_tb.sv
`timescale 1ns/1ps
// testbench for the register file with indexed addresser
// table of writes, reads and address requests checked against a byte model

module regs_ea_tb;

    localparam int VALID_TIMEOUT = 16;  // cycles allowed from request to ea_valid
    localparam int MODEL_BYTES   = reg_pkg::BANK_BYTES + reg_pkg::PTR_BYTES;

    typedef enum logic [1:0] {op_write, op_read, op_request} op_e;

    // one table step
    typedef struct {
        op_e                op;
        logic [1:0]         rfp;
        reg_pkg::reg_code_t code;      // write/read code or request base
        reg_pkg::reg_code_t off;       // offset register of a request
        reg_pkg::reg_size_e size;      // write size or pointer step
        reg_pkg::ea_mode_e  mode;
        logic               b2b;       // next entry issued on the following cycle
        reg_pkg::reg_long_t data;
        reg_pkg::reg_long_t exp_long;  // expected rd_data
        reg_pkg::ea_addr_t  exp_ea;    // expected ea_addr
    } entry_t;

    logic               clk;
    logic               rst_n;
    logic [1:0]         rfp;
    logic               wr_strobe;
    reg_pkg::reg_size_e wr_size;
    reg_pkg::reg_code_t wr_code;
    reg_pkg::reg_long_t wr_data;
    reg_pkg::reg_code_t rd_code;
    reg_pkg::reg_long_t rd_data;
    logic               ea_req;
    reg_pkg::ea_mode_e  ea_mode;
    reg_pkg::reg_size_e ea_step;
    reg_pkg::reg_code_t ea_base;
    reg_pkg::reg_code_t ea_off;
    logic               ea_valid;
    reg_pkg::ea_addr_t  ea_addr;

    logic [7:0] model_mem [MODEL_BYTES];  // 0..63 bank bytes, 64..79 pointer bytes
    entry_t     tbl [$];
    int         err_count;

    regs_ea_top regs_ea_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rfp       (rfp),
        .wr_strobe (wr_strobe),
        .wr_size   (wr_size),
        .wr_code   (wr_code),
        .wr_data   (wr_data),
        .rd_code   (rd_code),
        .rd_data   (rd_data),
        .ea_req    (ea_req),
        .ea_mode   (ea_mode),
        .ea_step   (ea_step),
        .ea_base   (ea_base),
        .ea_off    (ea_off),
        .ea_valid  (ea_valid),
        .ea_addr   (ea_addr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    task automatic abort_run(input string why);
        err_count++;
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    `include "regs_ea_tb_checks.svh"

    function automatic int byte_count(input reg_pkg::reg_size_e size);
        if (size == reg_pkg::size_long)
            return 4;
        return (size == reg_pkg::size_word) ? 2 : 1;
    endfunction

    // code -> model byte index, aligned down to the access size
    function automatic int phys_index(input reg_pkg::reg_code_t code, input logic [1:0] bank_ptr,
                                      input int nbytes);
        int low;
        int bank;
        low = code[3:0];
        low = low - (low % nbytes);
        if (code[7:4] == reg_pkg::PTR_NIB)
            return reg_pkg::BANK_BYTES + low;
        if (code[7:4] == reg_pkg::CUR_BANK_NIB)
            bank = bank_ptr;
        else if (code[7:4] == reg_pkg::PREV_BANK_NIB)
            bank = (bank_ptr + 3) % 4;  // one bank down, 0 wraps to 3
        else
            bank = code[5:4];           // direct code
        return bank * 16 + low;
    endfunction

    function automatic reg_pkg::reg_long_t model_read(input reg_pkg::reg_code_t code,
                                                      input logic [1:0] bank_ptr);
        int idx;
        idx = phys_index(code, bank_ptr, 4);
        return {model_mem[idx + 3], model_mem[idx + 2], model_mem[idx + 1], model_mem[idx]};
    endfunction

    task automatic model_write(input reg_pkg::reg_code_t code, input logic [1:0] bank_ptr,
                               input int nbytes, input reg_pkg::reg_long_t data);
        int idx;
        idx = phys_index(code, bank_ptr, nbytes);
        for (int b = 0; b < nbytes; b++)
            model_mem[idx + b] = data[8*b +: 8];  // lsb byte at the aligned code
    endtask

    function automatic reg_pkg::reg_code_t random_code();
        logic [7:0] r;
        r = 8'($urandom);
        case (r[7:6])
            2'd0:    return {2'b00, r[5:0]};                 // direct bank byte
            2'd1:    return {reg_pkg::CUR_BANK_NIB, r[3:0]};
            2'd2:    return {reg_pkg::PREV_BANK_NIB, r[3:0]};
            default: return {reg_pkg::PTR_NIB, r[3:0]};
        endcase
    endfunction

    task automatic add_write(input logic [1:0] bank_ptr, input reg_pkg::reg_code_t code,
                             input reg_pkg::reg_size_e size, input reg_pkg::reg_long_t data);
        model_write(code, bank_ptr, byte_count(size), data);
        tbl.push_back('{op_write, bank_ptr, code, 8'h00, size, reg_pkg::mode_indirect, 1'b0,
                        data, '0, '0});
    endtask

    task automatic add_read(input logic [1:0] bank_ptr, input reg_pkg::reg_code_t code);
        tbl.push_back('{op_read, bank_ptr, code, 8'h00, reg_pkg::size_long,
                        reg_pkg::mode_indirect, 1'b0, '0, model_read(code, bank_ptr), '0});
    endtask

    // expected address and pointer writeback straight from the mode rules
    task automatic add_request(input logic [1:0] bank_ptr, input reg_pkg::ea_mode_e mode,
                               input reg_pkg::reg_size_e step, input reg_pkg::reg_code_t base,
                               input reg_pkg::reg_code_t off, input logic b2b);
        reg_pkg::reg_long_t base_val;
        reg_pkg::reg_long_t off_val;
        reg_pkg::reg_long_t ea;
        logic [15:0]        word;
        base_val = model_read(base, bank_ptr);
        off_val  = model_read(off, bank_ptr);
        word     = off[1] ? off_val[31:16] : off_val[15:0];
        case (mode)
            reg_pkg::mode_offset:  ea = base_val + {{16{word[15]}}, word};
            reg_pkg::mode_pre_dec: ea = base_val - byte_count(step);
            default:               ea = base_val;
        endcase
        if (mode == reg_pkg::mode_post_inc)
            model_write(base, bank_ptr, 4, base_val + byte_count(step));
        else if (mode == reg_pkg::mode_pre_dec)
            model_write(base, bank_ptr, 4, ea);
        tbl.push_back('{op_request, bank_ptr, base, off, step, mode, b2b, '0, '0, ea[23:0]});
    endtask

    task automatic build_table();
        reg_pkg::reg_code_t code;
        logic [1:0]         bp;
        // fill every long first so the model holds no X
        for (int c = 0; c < 64; c += 4)
            add_write(2'd0, 8'(c), reg_pkg::size_long, $urandom);
        for (int c = 0; c < 16; c += 4)
            add_write(2'd0, 8'hF0 | 8'(c), reg_pkg::size_long, $urandom);
        for (int i = 0; i < 24; i++) begin
            bp   = 2'($urandom);
            code = random_code();
            add_write(bp, code, reg_pkg::reg_size_e'($urandom % 3), $urandom);
            add_read(bp, code);
        end
        add_write(2'd0, 8'hF7, reg_pkg::size_word, $urandom);  // odd code, aligned word
        add_read(2'd0, 8'hF4);
        add_write(2'd2, 8'hE5, reg_pkg::size_byte, $urandom);  // current bank 2
        add_read(2'd0, 8'h25);
        add_write(2'd0, 8'hD8, reg_pkg::size_long, $urandom);  // rfp 0, previous is bank 3
        add_read(2'd1, 8'h38);
        // offset words, positive low and negative high
        add_write(2'd0, 8'hF8, reg_pkg::size_word, 32'h0000_1234);
        add_write(2'd0, 8'hFA, reg_pkg::size_word, 32'h0000_8f00);
        add_request(2'd0, reg_pkg::mode_indirect, reg_pkg::size_byte, 8'hF0, 8'h00, 1'b0);
        add_read(2'd0, 8'hF0);
        add_request(2'd1, reg_pkg::mode_offset, reg_pkg::size_byte, 8'hE4, 8'hF8, 1'b0);
        add_read(2'd1, 8'hE4);
        add_request(2'd0, reg_pkg::mode_offset, reg_pkg::size_byte, 8'hF0, 8'hFA, 1'b0);
        add_read(2'd0, 8'hF0);
        for (int s = 0; s < 3; s++) begin
            add_request(2'd3, reg_pkg::mode_post_inc, reg_pkg::reg_size_e'(s), 8'hF4, 8'h00, 1'b0);
            add_read(2'd3, 8'hF4);
            add_request(2'd1, reg_pkg::mode_pre_dec, reg_pkg::reg_size_e'(s), 8'hDC, 8'h00, 1'b0);
            add_read(2'd1, 8'h0C);
        end
        // back-to-back pairs
        add_request(2'd0, reg_pkg::mode_pre_dec, reg_pkg::size_long, 8'hFC, 8'h00, 1'b1);
        add_request(2'd0, reg_pkg::mode_pre_dec, reg_pkg::size_long, 8'hFC, 8'h00, 1'b0);
        add_read(2'd0, 8'hFC);
        add_request(2'd2, reg_pkg::mode_post_inc, reg_pkg::size_word, 8'hE8, 8'h00, 1'b1);
        add_request(2'd2, reg_pkg::mode_offset, reg_pkg::size_byte, 8'hE8, 8'hFA, 1'b0);
        add_read(2'd2, 8'h28);
    endtask

    task automatic apply_write(input entry_t e);
        @(posedge clk);
        rfp       <= e.rfp;
        wr_strobe <= 1'b1;
        wr_size   <= e.size;
        wr_code   <= e.code;
        wr_data   <= e.data;
        @(posedge clk);         // write lands at this edge
        wr_strobe <= 1'b0;
    endtask

    task automatic read_back(input entry_t e);
        @(posedge clk);
        rfp     <= e.rfp;
        rd_code <= e.code;
        @(negedge clk);
        check_long("rd_data", rd_data, e.exp_long);
    endtask

    task automatic load_request(input entry_t e);
        rfp     <= e.rfp;
        ea_req  <= 1'b1;
        ea_mode <= e.mode;
        ea_step <= e.size;
        ea_base <= e.code;
        ea_off  <= e.off;
    endtask

    task automatic issue_request(input entry_t e);
        @(posedge clk);
        load_request(e);
        @(posedge clk);         // sampled here
        ea_req <= 1'b0;
        wait_ea_valid();
        check_ea("ea_addr", ea_addr, e.exp_ea);
        @(negedge clk);
        check_valid("ea_valid", ea_valid, 1'b0);  // one-cycle pulse
    endtask

    task automatic issue_pair(input entry_t a, input entry_t b);
        @(posedge clk);
        load_request(a);
        @(posedge clk);
        load_request(b);        // a sampled here
        wait_ea_valid();
        check_ea("ea_addr", ea_addr, a.exp_ea);
        @(posedge clk);
        ea_req <= 1'b0;         // b sampled here
        @(negedge clk);
        check_valid("ea_valid", ea_valid, 1'b1);
        check_ea("ea_addr", ea_addr, b.exp_ea);
        @(negedge clk);
        check_valid("ea_valid", ea_valid, 1'b0);
    endtask

    initial begin
        void'($urandom(32'hea73_96c3));  // single seed for the run
        err_count = 0;
        rst_n     <= 1'b0;
        rfp       <= 2'd0;
        wr_strobe <= 1'b0;
        wr_size   <= reg_pkg::size_byte;
        wr_code   <= 8'h00;
        wr_data   <= '0;
        rd_code   <= 8'h00;
        ea_req    <= 1'b0;
        ea_mode   <= reg_pkg::mode_indirect;
        ea_step   <= reg_pkg::size_byte;
        ea_base   <= 8'hF0;
        ea_off    <= 8'h00;
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < 4; i++) begin  // idle after reset
            @(negedge clk);
            check_valid("ea_valid", ea_valid, 1'b0);
            check_ea("ea_addr", ea_addr, '0);
        end
        for (int i = 0; i < tbl.size(); i++) begin
            case (tbl[i].op)
                op_write: apply_write(tbl[i]);
                op_read:  read_back(tbl[i]);
                default: begin
                    if (tbl[i].b2b) begin
                        issue_pair(tbl[i], tbl[i + 1]);
                        i++;    // second request consumed
                    end else begin
                        issue_request(tbl[i]);
                    end
                end
            endcase
        end
        repeat (2) @(posedge clk);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

//--- design/regs_ea_top.sv
`timescale 1ns/1ps
// register file with indexed memory addresser, plain port top level
// ties the register file, pointer stepper and address combiner together

module regs_ea_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [1:0]         rfp,        // current bank
    // host write port
    input  logic               wr_strobe,
    input  reg_pkg::reg_size_e wr_size,
    input  reg_pkg::reg_code_t wr_code,
    input  reg_pkg::reg_long_t wr_data,
    // host read port
    input  reg_pkg::reg_code_t rd_code,
    output reg_pkg::reg_long_t rd_data,
    // address request
    input  logic               ea_req,     // single-cycle strobe
    input  reg_pkg::ea_mode_e  ea_mode,
    input  reg_pkg::reg_size_e ea_step,
    input  reg_pkg::reg_code_t ea_base,    // long base register
    input  reg_pkg::reg_code_t ea_off,     // offset word register
    output logic               ea_valid,
    output reg_pkg::ea_addr_t  ea_addr
);

    reg_wr_if host_wr ();
    reg_wr_if ptr_wb ();   // driven by ptr_step

    reg_pkg::reg_long_t base_long;
    reg_pkg::reg_long_t off_long;
    reg_pkg::reg_long_t addr_base;

    // host write port onto the interface
    assign host_wr.strobe = wr_strobe;
    assign host_wr.size   = wr_size;
    assign host_wr.code   = wr_code;
    assign host_wr.data   = wr_data;

    reg_file reg_file_inst (
        .clk       (clk),
        .rfp       (rfp),
        .host_wr   (host_wr),
        .ptr_wb    (ptr_wb),
        .rd_code   (rd_code),
        .base_code (ea_base),
        .off_code  (ea_off),
        .rd_data   (rd_data),
        .base_long (base_long),
        .off_long  (off_long)
    );

    // runs beside the offset read path
    ptr_step ptr_step_inst (
        .req       (ea_req),
        .mode      (ea_mode),
        .step      (ea_step),
        .base_code (ea_base),
        .base_long (base_long),
        .addr_base (addr_base),
        .ptr_wb    (ptr_wb)
    );

    ea_combine ea_combine_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (ea_req),
        .mode      (ea_mode),
        .addr_base (addr_base),
        .off_long  (off_long),
        .off_code  (ea_off),
        .ea_valid  (ea_valid),
        .ea_addr   (ea_addr)
    );

endmodule

//--- design/ea_combine.sv
`timescale 1ns/1ps
// effective address combiner that adds the sign-extended offset word
// registers the 24-bit address with a single-cycle valid

module ea_combine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    input  reg_pkg::ea_mode_e  mode,
    input  reg_pkg::reg_long_t addr_base,   // already stepped for pre-decrement
    input  reg_pkg::reg_long_t off_long,    // aligned long holding the offset
    input  reg_pkg::reg_code_t off_code,
    output logic               ea_valid,
    output reg_pkg::ea_addr_t  ea_addr
);

    logic [15:0]        off_word;
    reg_pkg::reg_long_t off_sext;
    reg_pkg::reg_long_t ea_next;

    // bit 1 of the code picks the upper word
    assign off_word = off_code[1] ? off_long[31:16] : off_long[15:0];
    assign off_sext = {{16{off_word[15]}}, off_word};

    always_comb begin
        if (mode == reg_pkg::mode_offset)
            ea_next = addr_base + off_sext;
        else
            ea_next = addr_base;   // indirect, post-inc, pre-dec
    end

    // one cycle from req to valid with no hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ea_valid <= 1'b0;
            ea_addr  <= '0;
        end else begin
            ea_valid <= req;
            if (req)
                ea_addr <= ea_next[23:0];   // upper byte dropped
        end
    end

    // a request needs a known mode, base and offset word
    a_req_known: assert property (@(posedge clk) disable iff (!rst_n)
        req |-> !$isunknown({mode, ea_next}))
        else $error("address request with unknown mode, base or offset");

endmodule

//--- design/ptr_step.sv
`timescale 1ns/1ps
// pointer stepper for post-increment and pre-decrement addressing
// writes the stepped base back in the request cycle

module ptr_step (
    input  logic               req,
    input  reg_pkg::ea_mode_e  mode,
    input  reg_pkg::reg_size_e step,       // byte/word/long -> 1/2/4
    input  reg_pkg::reg_code_t base_code,
    input  reg_pkg::reg_long_t base_long,
    output reg_pkg::reg_long_t addr_base,  // base seen by the combiner
    reg_wr_if.source           ptr_wb
);

    reg_pkg::reg_long_t step_amt;
    reg_pkg::reg_long_t base_inc;
    reg_pkg::reg_long_t base_dec;
    logic               is_post;
    logic               is_pre;

    always_comb begin
        case (step)
            reg_pkg::size_word: step_amt = 32'd2;
            reg_pkg::size_long: step_amt = 32'd4;
            default:            step_amt = 32'd1;
        endcase
    end

    assign is_post  = (mode == reg_pkg::mode_post_inc);
    assign is_pre   = (mode == reg_pkg::mode_pre_dec);
    assign base_inc = base_long + step_amt;
    assign base_dec = base_long - step_amt;   // full 32-bit wrap

    // pre-decrement addresses with the new value
    assign addr_base = is_pre ? base_dec : base_long;

    // writeback, always a full long
    assign ptr_wb.strobe = req && (is_post || is_pre);
    assign ptr_wb.size   = reg_pkg::size_long;
    assign ptr_wb.code   = base_code;
    assign ptr_wb.data   = is_pre ? base_dec : base_inc;

    // stepped base must be a long aligned pointer or bank register
    always_comb begin
        if (ptr_wb.strobe) begin
            a_base_code: assert final ((base_code[1:0] == 2'b00) &&
                ((base_code[7:4] < 4'h4) || (base_code[7:4] >= reg_pkg::PREV_BANK_NIB)))
                else $error("stepping base code %h not a long register", base_code);
        end
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps
// general register file: 4 banks x 16 bytes plus 16 pointer bytes
// resolves bank codes through rfp, two long read ports, host read and two write ports

module reg_file (
    input  logic               clk,
    input  logic [1:0]         rfp,        // register file pointer, current bank
    reg_wr_if.sink             host_wr,    // writes from the memory data bus
    reg_wr_if.sink             ptr_wb,     // stepped pointer from ptr_step
    input  reg_pkg::reg_code_t rd_code,    // host read
    input  reg_pkg::reg_code_t base_code,  // addresser base
    input  reg_pkg::reg_code_t off_code,   // addresser offset
    output reg_pkg::reg_long_t rd_data,
    output reg_pkg::reg_long_t base_long,
    output reg_pkg::reg_long_t off_long
);

    logic [7:0] bank_mem [reg_pkg::BANK_BYTES];  // no reset, contents undefined
    logic [7:0] ptr_mem  [reg_pkg::PTR_BYTES];

    // per write port, index 0 host, 1 pointer writeback
    logic               wr_en  [2];
    logic [6:0]         wr_loc [2];  // bit 6 selects the pointer file
    logic [2:0]         wr_cnt [2];  // bytes to merge
    reg_pkg::reg_long_t wr_val [2];

    // code -> physical location, aligned by size
    function automatic logic [6:0] resolve(input reg_pkg::reg_code_t code,
                                           input reg_pkg::reg_size_e size);
        logic [3:0] nib;
        logic [5:0] idx;
        logic       is_ptr;
        nib    = code[7:4];
        is_ptr = (nib == reg_pkg::PTR_NIB);
        case (nib)
            reg_pkg::CUR_BANK_NIB:  idx = {rfp, code[3:0]};
            reg_pkg::PREV_BANK_NIB: idx = {rfp - 2'd1, code[3:0]};  // 2-bit, 0 wraps to 3
            reg_pkg::PTR_NIB:       idx = {2'b00, code[3:0]};
            default:                idx = code[5:0];              // direct bank byte
        endcase
        case (size)
            reg_pkg::size_word: idx[0]   = 1'b0;
            reg_pkg::size_long: idx[1:0] = 2'b00;
            default:            ;                     // byte keeps all bits
        endcase
        return {is_ptr, idx};
    endfunction

    function automatic logic [2:0] size_bytes(input reg_pkg::reg_size_e size);
        case (size)
            reg_pkg::size_word: return 3'd2;
            reg_pkg::size_long: return 3'd4;
            default:            return 3'd1;
        endcase
    endfunction

    // aligned long at a resolved location, lsb byte first
    function automatic reg_pkg::reg_long_t read_long(input logic [6:0] loc);
        reg_pkg::reg_long_t val;
        for (int b = 0; b < 4; b++) begin
            if (loc[6])
                val[8*b +: 8] = ptr_mem[loc[3:0] | 4'(b)];
            else
                val[8*b +: 8] = bank_mem[loc[5:0] | 6'(b)];
        end
        return val;
    endfunction

    // legal nibbles: 0..3 direct, D/E/F translated
    function automatic logic legal_code(input reg_pkg::reg_code_t code);
        return (code[7:4] < 4'h4) || (code[7:4] >= reg_pkg::PREV_BANK_NIB);
    endfunction

    // read ports, all combinational
    always_comb begin
        rd_data   = read_long(resolve(rd_code, reg_pkg::size_long));
        base_long = read_long(resolve(base_code, reg_pkg::size_long));
        off_long  = read_long(resolve(off_code, reg_pkg::size_long));
    end

    // gather both write ports for the merge loop
    always_comb begin
        wr_en[0]  = host_wr.strobe;
        wr_loc[0] = resolve(host_wr.code, host_wr.size);
        wr_cnt[0] = size_bytes(host_wr.size);
        wr_val[0] = host_wr.data;
        wr_en[1]  = ptr_wb.strobe;
        wr_loc[1] = resolve(ptr_wb.code, ptr_wb.size);
        wr_cnt[1] = size_bytes(ptr_wb.size);
        wr_val[1] = ptr_wb.data;
    end

    // byte merge, 1/2/4 bytes from the aligned location upward
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_en[p] && (b < wr_cnt[p])) begin
                    if (wr_loc[p][6])
                        ptr_mem[wr_loc[p][3:0] | 4'(b)] <= wr_val[p][8*b +: 8];
                    else
                        bank_mem[wr_loc[p][5:0] | 6'(b)] <= wr_val[p][8*b +: 8];
                end
            end
        end
    end

    // host must keep off the write port during a stepping request
    a_wr_excl: assert property (@(posedge clk) host_wr.strobe |-> !ptr_wb.strobe)
        else $error("host write and pointer writeback in the same cycle");

    // nibbles 4..C have no storage behind them
    a_wr_code: assert property (@(posedge clk)
        (host_wr.strobe |-> legal_code(host_wr.code)) and
        (ptr_wb.strobe |-> legal_code(ptr_wb.code)))
        else $error("write to illegal register code");

    a_rd_code: assert property (@(posedge clk) !$isunknown(rd_code) |-> legal_code(rd_code))
        else $error("read of illegal register code %h", rd_code);

endmodule

//--- design/reg_wr_if.sv
`timescale 1ns/1ps
// register write port shared by host writes and pointer writeback
// one write per rising edge with strobe high, no back-pressure

interface reg_wr_if;

    logic               strobe;   // write at this edge
    reg_pkg::reg_size_e size;     // byte, word or long
    reg_pkg::reg_code_t code;     // unresolved register code
    reg_pkg::reg_long_t data;     // lsb aligned, upper bytes unused for short writes

    // writer side
    modport source (
        output strobe, size, code, data
    );

    // register file side
    modport sink (
        input strobe, size, code, data
    );

endinterface

//--- design/reg_pkg.sv
// shared types and constants for the register file and indexed addresser
// register codes, access sizes and addressing modes

package reg_pkg;

    // register code, upper nibble picks the space
    // 0..3 direct bank byte, D previous bank, E current bank, F pointer
    typedef logic [7:0]  reg_code_t;

    // one register long, lsb byte at the aligned code
    typedef logic [31:0] reg_long_t;

    // effective address on the memory side
    typedef logic [23:0] ea_addr_t;

    // access size of a write or of a pointer step
    typedef enum logic [1:0] {
        size_byte = 2'd0,   // 1 byte, code used as is
        size_word = 2'd1,   // 2 bytes, code bit 0 ignored
        size_long = 2'd2    // 4 bytes, code bits 1:0 ignored
    } reg_size_e;

    // indexed addressing modes
    typedef enum logic [1:0] {
        mode_indirect = 2'd0,   // ea = base
        mode_offset   = 2'd1,   // ea = base + sext(word)
        mode_post_inc = 2'd2,   // ea = base, then base += step
        mode_pre_dec  = 2'd3    // base -= step, ea = new base
    } ea_mode_e;

    // code nibbles that need translation
    localparam logic [3:0] CUR_BANK_NIB  = 4'hE;  // bank chosen by rfp
    localparam logic [3:0] PREV_BANK_NIB = 4'hD;  // bank rfp-1, wraps 0 -> 3
    localparam logic [3:0] PTR_NIB       = 4'hF;  // pointer file

    // storage sizes
    localparam int BANK_BYTES = 64;   // 4 banks of 16 bytes
    localparam int PTR_BYTES  = 16;   // 4 pointer longs

endpackage
